//--- source/img_pkg.sv
package img_pkg;

    //////////////////////////////
    // frame geometry
    //////////////////////////////

    localparam int IMG_W = 8;
    localparam int IMG_H = 6;

    // one pixel of zeros on every side
    localparam int PAD_W = IMG_W + 2;
    localparam int PAD_H = IMG_H + 2;

    localparam int FB_DEPTH = PAD_W * PAD_H;

    // at or above this a pixel counts as foreground
    localparam int THRESHOLD = 140;

    //////////////////////////////
    // types
    //////////////////////////////

    typedef logic [7:0] pixel_t;
    typedef logic [6:0] fb_addr_t;

    // enough for IMG_W * IMG_H interior pixels
    typedef logic [5:0] pix_cnt_t;

endpackage

//--- source/ctrl_pkg.sv
package ctrl_pkg;

    //////////////////////////////
    // output flow control
    //////////////////////////////

    // words that may be in flight towards the sink
    localparam int CREDITS = 4;

    typedef logic [2:0] credit_t;

    //////////////////////////////
    // controller FSM
    //////////////////////////////

    typedef enum logic [1:0] {
        LOAD,
        ERODE,
        FLUSH
    } ctrl_state_t;

endpackage

//--- source/fb_if.sv
`timescale 1ns/1ps

interface fb_if;

    // write side, owned by the loader
    logic              wr_en;
    img_pkg::fb_addr_t wr_addr;
    img_pkg::pixel_t   wr_data;

    // read side, data one cycle after the address
    img_pkg::fb_addr_t rd_addr;
    img_pkg::pixel_t   rd_data;

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_addr,
        input  rd_data
    );

    modport mem (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output rd_data
    );

endinterface

//--- source/bw_loader.sv
`timescale 1ns/1ps

module bw_loader (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            load_start_i,
    output logic            load_done_o,
    input  logic            in_valid_i,
    input  img_pkg::pixel_t in_data_i,
    output logic            in_ready_o,
    fb_if.writer            fb
);

    logic              active_q;
    logic [2:0]        prow_q;
    logic [3:0]        pcol_q;
    img_pkg::fb_addr_t addr_q;
    logic              border;
    logic              last;
    logic              adv;

    assign border = (prow_q == 0) || (prow_q == img_pkg::PAD_H - 1) ||
                    (pcol_q == 0) || (pcol_q == img_pkg::PAD_W - 1);
    assign last   = (prow_q == img_pkg::PAD_H - 1) && (pcol_q == img_pkg::PAD_W - 1);

    // border cells never wait for input
    assign in_ready_o = active_q && !border;
    assign adv        = active_q && (border || in_valid_i);

    assign fb.wr_en   = adv;
    assign fb.wr_addr = addr_q;
    assign fb.wr_data = (border || in_data_i < img_pkg::pixel_t'(img_pkg::THRESHOLD)) ?
                        8'd0 : 8'd255;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            active_q    <= 1'b0;
            load_done_o <= 1'b0;
            prow_q      <= '0;
            pcol_q      <= '0;
            addr_q      <= '0;
        end else begin
            load_done_o <= adv && last;
            if (load_start_i) begin
                active_q <= 1'b1;
                prow_q   <= '0;
                pcol_q   <= '0;
                addr_q   <= '0;
            end else if (adv) begin
                addr_q <= addr_q + 1'b1;
                if (pcol_q == img_pkg::PAD_W - 1) begin
                    pcol_q <= '0;
                    prow_q <= prow_q + 1'b1;
                end else begin
                    pcol_q <= pcol_q + 1'b1;
                end
                if (last) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    // raster scan ends exactly on the last padded cell
    a_last_addr: assert property (@(posedge clk_i) disable iff (!rst_i)
        adv && last |-> fb.wr_addr == img_pkg::FB_DEPTH - 1);

endmodule

//--- source/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
    input logic clk_i,
    fb_if.mem   fb
);

    //////////////////////////////
    // padded pixel store
    //////////////////////////////

    img_pkg::pixel_t mem_q [img_pkg::FB_DEPTH];

    always_ff @(posedge clk_i) begin
        if (fb.wr_en) begin
            mem_q[fb.wr_addr] <= fb.wr_data;
        end
    end

    // registered read, one cycle after the address
    always_ff @(posedge clk_i) begin
        fb.rd_data <= mem_q[fb.rd_addr];
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    a_wr_range: assert property (@(posedge clk_i)
        fb.wr_en |-> fb.wr_addr < img_pkg::FB_DEPTH);

endmodule

//--- source/boundary_kernel.sv
`timescale 1ns/1ps

module boundary_kernel (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              kern_start_i,
    input  img_pkg::fb_addr_t center_addr_i,
    output logic              kern_done_o,
    fb_if.reader              fb,
    output logic              pix_valid_o,
    output img_pkg::pixel_t   pix_data_o,
    input  logic              pix_ready_i
);

    logic              busy_q;
    logic [3:0]        step_q;
    logic [1:0]        col_q;
    logic              pix_valid_q;
    img_pkg::fb_addr_t addr_q;
    img_pkg::pixel_t   min_q;
    img_pkg::pixel_t   center_q;

    assign fb.rd_addr  = addr_q;
    assign pix_valid_o = pix_valid_q;

    // centre is in the minimum, so this never wraps
    assign pix_data_o  = center_q - min_q;
    assign kern_done_o = pix_valid_q && pix_ready_i;

    //////////////////////////////
    // tap sequencing
    //////////////////////////////

    // step 0..8 issues taps, step 1..9 captures them
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_q      <= 1'b0;
            step_q      <= '0;
            col_q       <= '0;
            pix_valid_q <= 1'b0;
        end else begin
            if (kern_start_i) begin
                busy_q <= 1'b1;
                step_q <= '0;
                col_q  <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                col_q  <= (col_q == 2'd2) ? 2'd0 : col_q + 1'b1;
                if (step_q == 4'd9) begin
                    busy_q      <= 1'b0;
                    pix_valid_q <= 1'b1;
                end
            end
            if (kern_done_o) begin
                pix_valid_q <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // window datapath
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (kern_start_i) begin
            addr_q <= center_addr_i - img_pkg::fb_addr_t'(img_pkg::PAD_W + 1);
            min_q  <= '1;
        end else if (busy_q) begin
            // wrap to the next window row after the third column
            if (step_q < 4'd8) begin
                addr_q <= (col_q == 2'd2) ?
                          addr_q + img_pkg::fb_addr_t'(img_pkg::PAD_W - 2) :
                          addr_q + 1'b1;
            end
            if (step_q != 4'd0) begin
                if (fb.rd_data < min_q) begin
                    min_q <= fb.rd_data;
                end
                if (step_q == 4'd5) begin
                    center_q <= fb.rd_data;
                end
            end
        end
    end

    a_hold_valid: assert property (@(posedge clk_i) disable iff (!rst_i)
        pix_valid_o && !pix_ready_i |=> pix_valid_o && $stable(pix_data_o));

endmodule

//--- source/credit_tx.sv
`timescale 1ns/1ps

module credit_tx (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            pix_valid_i,
    input  img_pkg::pixel_t pix_data_i,
    output logic            pix_ready_o,
    output logic            out_valid_o,
    output img_pkg::pixel_t out_data_o,
    input  logic            credit_i,
    output logic            empty_o
);

    logic              full_q;
    img_pkg::pixel_t   data_q;
    ctrl_pkg::credit_t credit_q;

    assign pix_ready_o = !full_q;
    assign empty_o     = !full_q;
    assign out_valid_o = full_q && (credit_q != '0);
    assign out_data_o  = data_q;

    // one word holding register
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            full_q <= 1'b0;
        end else if (pix_valid_i && pix_ready_o) begin
            full_q <= 1'b1;
        end else if (out_valid_o) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pix_valid_i && pix_ready_o) begin
            data_q <= pix_data_i;
        end
    end

    // credits in from the sink, out with each word
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            credit_q <= ctrl_pkg::credit_t'(ctrl_pkg::CREDITS);
        end else begin
            case ({credit_i, out_valid_o})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_i)
        credit_q <= ctrl_pkg::CREDITS);

    a_no_credit: assert property (@(posedge clk_i) disable iff (!rst_i)
        credit_q == '0 && !credit_i |=> !out_valid_o);

endmodule

//--- source/boundary_ctrl.sv
`timescale 1ns/1ps

module boundary_ctrl (
    input  logic              clk_i,
    input  logic              rst_i,
    output logic              load_start_o,
    input  logic              load_done_i,
    output logic              kern_start_o,
    output img_pkg::fb_addr_t center_addr_o,
    input  logic              kern_done_i,
    input  logic              tx_empty_i,
    output logic              frame_done_o
);

    ctrl_pkg::ctrl_state_t state_q;
    logic                  load_pend_q;
    logic [2:0]            row_q;
    logic [2:0]            col_q;
    img_pkg::pix_cnt_t     pix_cnt_q;

    // interior position shifted past the zero border
    assign center_addr_o = img_pkg::fb_addr_t'((row_q + 1) * img_pkg::PAD_W + col_q + 1);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q      <= ctrl_pkg::LOAD;
            load_pend_q  <= 1'b1;
            load_start_o <= 1'b0;
            kern_start_o <= 1'b0;
            frame_done_o <= 1'b0;
            row_q        <= '0;
            col_q        <= '0;
            pix_cnt_q    <= '0;
        end else begin
            load_start_o <= 1'b0;
            kern_start_o <= 1'b0;
            frame_done_o <= 1'b0;
            case (state_q)
                ctrl_pkg::LOAD: begin
                    if (load_pend_q) begin
                        load_start_o <= 1'b1;
                        load_pend_q  <= 1'b0;
                    end
                    if (load_done_i) begin
                        state_q      <= ctrl_pkg::ERODE;
                        kern_start_o <= 1'b1;
                        row_q        <= '0;
                        col_q        <= '0;
                        pix_cnt_q    <= '0;
                    end
                end
                ctrl_pkg::ERODE: begin
                    if (kern_done_i) begin
                        if (pix_cnt_q == img_pkg::IMG_W * img_pkg::IMG_H - 1) begin
                            state_q <= ctrl_pkg::FLUSH;
                        end else begin
                            pix_cnt_q    <= pix_cnt_q + 1'b1;
                            kern_start_o <= 1'b1;
                            if (col_q == img_pkg::IMG_W - 1) begin
                                col_q <= '0;
                                row_q <= row_q + 1'b1;
                            end else begin
                                col_q <= col_q + 1'b1;
                            end
                        end
                    end
                end
                // last word still in the transmitter
                ctrl_pkg::FLUSH: begin
                    if (tx_empty_i) begin
                        state_q      <= ctrl_pkg::LOAD;
                        frame_done_o <= 1'b1;
                        load_pend_q  <= 1'b1;
                    end
                end
                default: state_q <= ctrl_pkg::LOAD;
            endcase
        end
    end

    a_start_erode: assert property (@(posedge clk_i) disable iff (!rst_i)
        kern_start_o |-> state_q == ctrl_pkg::ERODE);

endmodule

//--- source/boundary_top.sv
`timescale 1ns/1ps

module boundary_top (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            in_valid_i,
    input  img_pkg::pixel_t in_data_i,
    output logic            in_ready_o,
    output logic            out_valid_o,
    output img_pkg::pixel_t out_data_o,
    input  logic            credit_i,
    output logic            frame_done_o
);

    logic              load_start;
    logic              load_done;
    logic              kern_start;
    logic              kern_done;
    img_pkg::fb_addr_t center_addr;
    logic              pix_valid;
    img_pkg::pixel_t   pix_data;
    logic              pix_ready;
    logic              tx_empty;

    fb_if fb ();

    bw_loader i_loader (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_start_i (load_start),
        .load_done_o  (load_done),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .in_ready_o   (in_ready_o),
        .fb           (fb.writer)
    );

    frame_buffer i_fb (
        .clk_i (clk_i),
        .fb    (fb.mem)
    );

    boundary_kernel i_kernel (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .kern_start_i  (kern_start),
        .center_addr_i (center_addr),
        .kern_done_o   (kern_done),
        .fb            (fb.reader),
        .pix_valid_o   (pix_valid),
        .pix_data_o    (pix_data),
        .pix_ready_i   (pix_ready)
    );

    credit_tx i_tx (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .pix_valid_i (pix_valid),
        .pix_data_i  (pix_data),
        .pix_ready_o (pix_ready),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .credit_i    (credit_i),
        .empty_o     (tx_empty)
    );

    boundary_ctrl i_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .load_start_o  (load_start),
        .load_done_i   (load_done),
        .kern_start_o  (kern_start),
        .center_addr_o (center_addr),
        .kern_done_i   (kern_done),
        .tx_empty_i    (tx_empty),
        .frame_done_o  (frame_done_o)
    );

endmodule

//--- tb/tb_boundary.sv
`timescale 1ns/1ps

module tb_boundary;

    localparam int NPIX       = img_pkg::IMG_W * img_pkg::IMG_H;
    localparam int GAP_MAX    = 3;
    localparam int STARVE_MAX = 40;
    // load, input gaps, one kernel pass plus the longest credit wait per word
    localparam int FRAME_CYCLES = img_pkg::FB_DEPTH + NPIX * (GAP_MAX + 1) +
                                  NPIX * (20 + STARVE_MAX) + 20;

    logic            clk_i;
    logic            rst_i      = 1'b0;
    logic            in_valid_i = 1'b0;
    img_pkg::pixel_t in_data_i  = '0;
    logic            in_ready_o;
    logic            out_valid_o;
    img_pkg::pixel_t out_data_o;
    logic            credit_i   = 1'b0;
    logic            frame_done_o;

    logic [31:0]     stim_lfsr   = 32'h820a;
    logic [31:0]     credit_lfsr = 32'h820a;
    logic            starve_q    = 1'b0;
    int              credit_wait;
    int              outstanding_q;
    int              in_cnt_q;
    int              out_cnt_q;
    int              frames_done_q;
    int              value_errs;
    int              proto_errs;
    img_pkg::pixel_t in_frame [NPIX];
    img_pkg::pixel_t exp_mem  [NPIX];

    boundary_top i_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .in_ready_o   (in_ready_o),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .credit_i     (credit_i),
        .frame_done_o (frame_done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    //////////////////////////////
    // random source
    //////////////////////////////

    // galois form, taps 32 22 2 1
    function automatic int take_bits(inout logic [31:0] state, input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(state[0]);
            state = (state >> 1) ^ (state[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////

    // thresholded pixel, zero outside the frame
    function automatic img_pkg::pixel_t binary_at(int r, int c);
        if (r < 0 || r >= img_pkg::IMG_H || c < 0 || c >= img_pkg::IMG_W) begin
            return 8'd0;
        end
        return (in_frame[r * img_pkg::IMG_W + c] >= img_pkg::THRESHOLD) ? 8'd255 : 8'd0;
    endfunction

    function automatic img_pkg::pixel_t boundary_value(int r, int c);
        img_pkg::pixel_t lo;
        lo = 8'd255;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                if (binary_at(r + dr, c + dc) < lo) begin
                    lo = binary_at(r + dr, c + dc);
                end
            end
        end
        return binary_at(r, c) - lo;
    endfunction

    always @(posedge clk_i) begin
        img_pkg::pixel_t exp_next [NPIX];
        if (!rst_i || frame_done_o) begin
            in_cnt_q <= 0;
        end else if (in_valid_i && in_ready_o) begin
            in_frame[in_cnt_q] = in_data_i;
            in_cnt_q <= in_cnt_q + 1;
            if (in_cnt_q == NPIX - 1) begin
                for (int k = 0; k < NPIX; k++) begin
                    exp_next[k] = boundary_value(k / img_pkg::IMG_W, k % img_pkg::IMG_W);
                end
                exp_mem <= exp_next;
            end
        end
    end

    always @(posedge clk_i) begin
        if (!rst_i) begin
            out_cnt_q     <= 0;
            frames_done_q <= 0;
        end else if (frame_done_o) begin
            out_cnt_q     <= 0;
            frames_done_q <= frames_done_q + 1;
        end else if (out_valid_o) begin
            out_cnt_q <= out_cnt_q + 1;
        end
    end

    //////////////////////////////
    // credit return
    //////////////////////////////

    // starved frames only return a credit now and then
    always @(posedge clk_i) begin
        int next_out;
        logic due;
        next_out = outstanding_q + int'(out_valid_o) - int'(credit_i);
        due = 1'b0;
        if (!rst_i) begin
            outstanding_q <= 0;
            credit_i      <= 1'b0;
            credit_wait = 0;
        end else begin
            outstanding_q <= next_out;
            if (next_out > 0) begin
                if (starve_q) begin
                    due = (take_bits(credit_lfsr, 4) == 15) || (credit_wait >= STARVE_MAX);
                end else begin
                    due = (take_bits(credit_lfsr, 1) == 1) || (credit_wait >= 3);
                end
                credit_wait = due ? 0 : credit_wait + 1;
            end else begin
                credit_wait = 0;
            end
            credit_i <= due;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    a_reset_quiet: assert property (@(posedge clk_i) $rose(rst_i) |-> !out_valid_o && !frame_done_o)
        else begin
            proto_errs++;
            $display("output or frame done active right after reset at %0t", $time);
        end

    a_out_value: assert property (@(posedge clk_i) disable iff (!rst_i)
        out_valid_o |-> out_data_o == exp_mem[out_cnt_q])
        else begin
            value_errs++;
            $display("Fail %0t: word %0d of frame %0d is %0d, expected %0d", $time,
                     $sampled(out_cnt_q), frames_done_q + 1, $sampled(out_data_o),
                     exp_mem[$sampled(out_cnt_q)]);
        end

    a_out_count: assert property (@(posedge clk_i) disable iff (!rst_i)
        out_valid_o |-> out_cnt_q < NPIX)
        else begin
            proto_errs++;
            $display("more output words than pixels in a frame at %0t", $time);
        end

    a_done_count: assert property (@(posedge clk_i) disable iff (!rst_i)
        frame_done_o |-> out_cnt_q == NPIX && in_cnt_q == NPIX)
        else begin
            proto_errs++;
            $display("frame done with %0d inputs and %0d outputs at %0t",
                     $sampled(in_cnt_q), $sampled(out_cnt_q), $time);
        end

    a_credit_limit: assert property (@(posedge clk_i) disable iff (!rst_i)
        outstanding_q <= ctrl_pkg::CREDITS)
        else begin
            proto_errs++;
            $display("more words in flight than credits allow at %0t", $time);
        end

    a_ready_closed: assert property (@(posedge clk_i) disable iff (!rst_i)
        in_cnt_q == NPIX |-> !in_ready_o)
        else begin
            proto_errs++;
            $display("input ready raised after the frame was complete at %0t", $time);
        end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic send_frame(input logic flat);
        int sent;
        int gap;
        sent = 0;
        gap  = take_bits(stim_lfsr, 2);
        while (sent < NPIX) begin
            @(posedge clk_i);
            if (in_valid_i && in_ready_o) begin
                sent++;
                gap = take_bits(stim_lfsr, 2);
                in_valid_i <= 1'b0;
            end
            // slot free once the current pixel is gone
            if (sent < NPIX && (!in_valid_i || in_ready_o)) begin
                if (gap == 0) begin
                    in_valid_i <= 1'b1;
                    in_data_i  <= flat ? 8'd200 : img_pkg::pixel_t'(take_bits(stim_lfsr, 8));
                end else begin
                    gap--;
                end
            end
        end
    endtask

    task automatic wait_frame_done();
        do begin
            @(posedge clk_i);
        end while (!frame_done_o);
    endtask

    initial begin
        value_errs = 0;
        proto_errs = 0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b1;
        send_frame(1'b0);
        wait_frame_done();
        send_frame(1'b1);
        wait_frame_done();
        starve_q <= 1'b1;
        send_frame(1'b0);
        wait_frame_done();
        repeat (4) @(posedge clk_i);
        if (frames_done_q != 3) begin
            proto_errs++;
            $display("expected 3 frame done pulses, saw %0d", frames_done_q);
        end
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (4 * FRAME_CYCLES) @(posedge clk_i);
        $display("timeout: frames did not complete in time, %0d done", frames_done_q);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- all.f
source/img_pkg.sv
source/ctrl_pkg.sv
source/fb_if.sv
source/bw_loader.sv
source/frame_buffer.sv
source/boundary_kernel.sv
source/credit_tx.sv
source/boundary_ctrl.sv
source/boundary_top.sv
tb/tb_boundary.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_boundary \
    -f all.f -o sim_boundary
sim_out=$(./obj_dir/sim_boundary)
echo "$sim_out"

if echo "$sim_out" | grep -q "^RESULT: PASS$"; then
    exit 0
else
    exit 1
fi
